// ==== compile.f ====
vread_pkg.sv
burst_reader.sv
addr_gen.sv
write_join.sv
two_port_buffer.sv
vread_unit.sv
tb_vread_unit.sv

// ==== run.sh ====
#!/bin/sh
# build and run the vread_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_vread_unit
status=$?
if [ $status -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/Vtb_vread_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "TESTS PASSED"; then
   exit 0
else
   exit 1
fi

// ==== tb_vread_unit.sv ====
`timescale 1ns/1ns

module tb_vread_unit;

   logic                         clk = 1'b0;
   logic                         rst;
   logic                         run_i;
   vread_pkg::read_cfg_t         read_cfg;
   vread_pkg::gen_cfg_t          read_gen_cfg;
   vread_pkg::gen_cfg_t          out_gen_cfg;
   vread_pkg::bus_rsp_t          bus_rsp = '0;
   vread_pkg::bus_req_t          bus_req;
   logic                         out_valid;
   logic [vread_pkg::DATA_W-1:0] out_data;
   logic                         done;

   integer                           seed = 32'h481d;
   int                               stall_pct = 25;
   int                               beat_idx = 0;
   logic                             burst_open = 1'b0;
   vread_pkg::bus_req_t              req_log[$];
   logic [vread_pkg::DATA_W-1:0]     out_q[$];
   logic [vread_pkg::BUF_ADDR_W-1:0] exp_addr_q[$];

   vread_unit i_vread_unit (
      .clk            (clk),
      .rst            (rst),
      .run_i          (run_i),
      .read_cfg_i     (read_cfg),
      .read_gen_cfg_i (read_gen_cfg),
      .out_gen_cfg_i  (out_gen_cfg),
      .bus_rsp_i      (bus_rsp),
      .bus_req_o      (bus_req),
      .out_valid_o    (out_valid),
      .out_data_o     (out_data),
      .done_o         (done)
   );

   always #20 clk = ~clk;

   function automatic logic [vread_pkg::DATA_W-1:0] mem_word(input logic [31:0] byte_addr);
      return byte_addr ^ 32'h5a5a0000;
   endfunction

   // a beat offered at the falling edge moves at the next rising edge
   always @(negedge clk) begin
      if (bus_rsp.ready) begin
         if (bus_rsp.last) begin
            burst_open = 1'b0;
         end else begin
            beat_idx = beat_idx + 1;
         end
      end
      bus_rsp = '0;
      if (!rst && bus_req.valid) begin
         if (!burst_open) begin
            req_log.push_back(bus_req);
            burst_open = 1'b1;
            beat_idx   = 0;
         end
         if (($unsigned($random(seed)) % 100) >= stall_pct) begin
            bus_rsp.ready = 1'b1;
            bus_rsp.rdata = mem_word(bus_req.addr + 32'(beat_idx) * 4);
            bus_rsp.last  = (beat_idx == int'(bus_req.len));
         end
      end
   end

   always @(negedge clk) begin
      if (out_valid) begin
         out_q.push_back(out_data);
      end
   end

   task automatic abort_run();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [vread_pkg::DATA_W-1:0] got,
                             input logic [vread_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_req(input string name, input vread_pkg::bus_req_t got,
                            input vread_pkg::bus_req_t exp);
      if (got !== exp) begin
         $display("[FAIL] %s got valid %h addr %h len %h expected valid %h addr %h len %h",
                  name, got.valid, got.addr, got.len, exp.valid, exp.addr, exp.len);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[FAIL] %s got %h expected %h", name, got, exp);
         abort_run();
      end
   endtask

   // consecutive words into buffer 0..n-1 and read back over the same range
   task automatic set_linear(input logic [31:0] base, input int n, input logic pp);
      read_cfg.ext_addr         = base;
      read_cfg.addr_shift       = 32'd32;
      read_cfg.amount_minus_one = 8'(n - 1);
      read_cfg.burst_len        = 8'd7;
      read_cfg.enabled          = 1'b1;
      read_cfg.pingpong         = pp;
      read_gen_cfg.start        = '0;
      read_gen_cfg.incr         = 7'd1;
      read_gen_cfg.shift        = '0;
      read_gen_cfg.period       = 6'd1;
      read_gen_cfg.duty         = 6'd1;
      read_gen_cfg.iterations   = 8'(n);
      read_gen_cfg.delay        = '0;
      out_gen_cfg               = read_gen_cfg;
      out_gen_cfg.delay         = 4'd2;
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      while (!done && n < 3000) begin
         @(negedge clk);
         n = n + 1;
      end
      if (!done) begin
         $display("done_o did not rise within 3000 cycles after run");
         abort_run();
      end
   endtask

   task automatic do_run();
      out_q.delete();
      @(negedge clk);
      run_i = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      check_bit("done_o", done, 1'b0);
      wait_done();
   endtask

   // addresses the output generator should emit for its period, duty, incr and shift
   task automatic expect_addrs(input vread_pkg::gen_cfg_t cfg);
      logic [vread_pkg::BUF_ADDR_W-1:0] a;
      int                               it;
      int                               p;
      exp_addr_q.delete();
      a = cfg.start;
      for (it = 0; it < int'(cfg.iterations); it++) begin
         for (p = 0; p < int'(cfg.period); p++) begin
            if (p < int'(cfg.duty)) begin
               exp_addr_q.push_back(a);
               a = a + cfg.incr;
            end
            if (p == int'(cfg.period) - 1) begin
               a = a + cfg.shift;
            end
         end
      end
   endtask

   // buffer word k came from bus address base + 4k
   task automatic check_output(input logic [31:0] base);
      int i;
      expect_addrs(out_gen_cfg);
      check_word("out_valid_o count", out_q.size(), exp_addr_q.size());
      for (i = 0; i < exp_addr_q.size(); i++) begin
         check_word("out_data_o", out_q[i],
                    mem_word(base + {26'b0, exp_addr_q[i][5:0]} * 4));
      end
   endtask

   task automatic test_reset_done();
      check_bit("done_o", done, 1'b1);
      check_bit("bus_req_o.valid", bus_req.valid, 1'b0);
      check_bit("out_valid_o", out_valid, 1'b0);
      set_linear(32'h0000_0400, 20, 1'b0);
      do_run();
   endtask

   task automatic test_burst_split();
      vread_pkg::bus_req_t exp;
      int                  i;
      req_log.delete();
      set_linear(32'h0000_1000, 20, 1'b0);
      do_run();
      check_word("burst count", req_log.size(), 3);
      for (i = 0; i < 3; i++) begin
         exp.valid = 1'b1;
         exp.addr  = 32'h0000_1000 + 32'(i) * 32;
         exp.len   = (i == 2) ? 8'd3 : 8'd7;
         check_req("bus_req_o", req_log[i], exp);
      end
   endtask

   task automatic test_linear();
      set_linear(32'h0000_2000, 20, 1'b0);
      do_run();
      do_run();
      check_output(32'h0000_2000);
   endtask

   task automatic test_pattern();
      read_cfg.enabled       = 1'b0;
      out_gen_cfg.start      = '0;
      out_gen_cfg.incr       = 7'd1;
      out_gen_cfg.shift      = 7'd5;
      out_gen_cfg.period     = 6'd4;
      out_gen_cfg.duty       = 6'd2;
      out_gen_cfg.iterations = 8'd3;
      out_gen_cfg.delay      = 4'd1;
      do_run();
      check_word("out_valid_o pulses", out_q.size(), 6);
      check_output(32'h0000_2000);
   endtask

   task automatic test_pingpong();
      set_linear(32'h0000_3000, 20, 1'b1);
      do_run();
      set_linear(32'h0000_4400, 20, 1'b1);
      do_run();
      check_output(32'h0000_3000);
      set_linear(32'h0000_5800, 20, 1'b1);
      do_run();
      check_output(32'h0000_4400);
   endtask

   task automatic test_no_fill();
      req_log.delete();
      set_linear(32'h0000_7000, 20, 1'b0);
      read_cfg.enabled = 1'b0;
      do_run();
      check_word("bus request count", req_log.size(), 0);
   endtask

   task automatic test_backpressure();
      stall_pct = 80;
      set_linear(32'h0000_6000, 20, 1'b0);
      do_run();
      do_run();
      check_output(32'h0000_6000);
      stall_pct = 25;
   endtask

   initial begin
      rst          = 1'b1;
      run_i        = 1'b0;
      read_cfg     = '0;
      read_gen_cfg = '0;
      out_gen_cfg  = '0;
      repeat (5) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      test_reset_done();
      test_burst_split();
      test_linear();
      test_pattern();
      test_pingpong();
      test_no_fill();
      test_backpressure();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

// ==== vread_unit.sv ====
`timescale 1ns/1ns

module vread_unit (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         run_i,
   input  vread_pkg::read_cfg_t         read_cfg_i,
   input  vread_pkg::gen_cfg_t          read_gen_cfg_i,
   input  vread_pkg::gen_cfg_t          out_gen_cfg_i,
   input  vread_pkg::bus_rsp_t          bus_rsp_i,
   output vread_pkg::bus_req_t          bus_req_o,
   output logic                         out_valid_o,
   output logic [vread_pkg::DATA_W-1:0] out_data_o,
   output logic                         done_o
);

   logic                             run_go;
   logic                             fill_go;
   logic                             bank_q;
   logic                             fill_done_q;
   logic                             out_done_q;
   logic                             out_valid_q;
   logic [vread_pkg::COUNT_W:0]      read_count;
   vread_pkg::gen_cfg_t              rd_gen_cfg;
   logic                             data_valid;
   logic                             data_ready;
   logic [vread_pkg::DATA_W-1:0]     data;
   logic                             reader_done;
   logic                             wgen_valid;
   logic                             wgen_ready;
   logic [vread_pkg::BUF_ADDR_W-1:0] wgen_addr;
   logic [vread_pkg::BUF_ADDR_W-1:0] wr_addr;
   logic                             ogen_valid;
   logic [vread_pkg::BUF_ADDR_W-1:0] ogen_addr;
   logic [vread_pkg::BUF_ADDR_W-1:0] rd_addr;
   logic                             ogen_done;
   vread_pkg::buf_wr_t               buf_wr;

   assign run_go     = run_i && done_o;
   assign fill_go    = run_go && read_cfg_i.enabled;
   assign read_count = {1'b0, read_cfg_i.amount_minus_one} + 1'b1;

   // write side never waits before starting
   always_comb begin
      rd_gen_cfg       = read_gen_cfg_i;
      rd_gen_cfg.delay = '0;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bank_q      <= 1'b0;
         fill_done_q <= 1'b1;
         out_done_q  <= 1'b1;
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= ogen_valid;
         if (run_go) begin
            bank_q      <= read_cfg_i.pingpong ? !bank_q : 1'b0;
            fill_done_q <= !read_cfg_i.enabled;
            out_done_q  <= 1'b0;
         end else begin
            if (reader_done) begin
               fill_done_q <= 1'b1;
            end
            if (ogen_done) begin
               out_done_q <= 1'b1;
            end
         end
      end
   end

   // fill goes to the bank not being streamed out
   assign wr_addr = read_cfg_i.pingpong ?
                    {!bank_q, wgen_addr[vread_pkg::BUF_ADDR_W-2:0]} : wgen_addr;
   assign rd_addr = read_cfg_i.pingpong ?
                    {bank_q, ogen_addr[vread_pkg::BUF_ADDR_W-2:0]} : ogen_addr;

   burst_reader i_burst_reader (
      .clk          (clk),
      .rst          (rst),
      .start_i      (fill_go),
      .count_i      (read_count),
      .start_addr_i (read_cfg_i.ext_addr),
      .addr_shift_i (read_cfg_i.addr_shift),
      .burst_len_i  (read_cfg_i.burst_len),
      .bus_rsp_i    (bus_rsp_i),
      .data_ready_i (data_ready),
      .bus_req_o    (bus_req_o),
      .data_valid_o (data_valid),
      .data_o       (data),
      .done_o       (reader_done)
   );

   addr_gen i_read_gen (
      .clk     (clk),
      .rst     (rst),
      .start_i (fill_go),
      .cfg_i   (rd_gen_cfg),
      .ready_i (wgen_ready),
      .valid_o (wgen_valid),
      .addr_o  (wgen_addr),
      .done_o  ()
   );

   addr_gen i_out_gen (
      .clk     (clk),
      .rst     (rst),
      .start_i (run_go),
      .cfg_i   (out_gen_cfg_i),
      .ready_i (1'b1),
      .valid_o (ogen_valid),
      .addr_o  (ogen_addr),
      .done_o  (ogen_done)
   );

   write_join i_write_join (
      .clk          (clk),
      .rst          (rst),
      .addr_valid_i (wgen_valid),
      .addr_i       (wr_addr),
      .data_valid_i (data_valid),
      .data_i       (data),
      .addr_ready_o (wgen_ready),
      .data_ready_o (data_ready),
      .wr_o         (buf_wr)
   );

   two_port_buffer i_buffer (
      .clk       (clk),
      .wr_i      (buf_wr),
      .rd_en_i   (ogen_valid),
      .rd_addr_i (rd_addr),
      .rd_data_o (out_data_o)
   );

   assign out_valid_o = out_valid_q;
   assign done_o      = fill_done_q && out_done_q;

   // in ping-pong mode a generator must stay inside one bank
   a_bank_range: assert property (@(posedge clk) disable iff (rst)
      read_cfg_i.pingpong && (wgen_valid || ogen_valid) |->
      !(wgen_valid && wgen_addr[vread_pkg::BUF_ADDR_W-1]) &&
      !(ogen_valid && ogen_addr[vread_pkg::BUF_ADDR_W-1]));

endmodule

// ==== two_port_buffer.sv ====
`timescale 1ns/1ns

module two_port_buffer (
   input  logic                             clk,
   input  vread_pkg::buf_wr_t               wr_i,
   input  logic                             rd_en_i,
   input  logic [vread_pkg::BUF_ADDR_W-1:0] rd_addr_i,
   output logic [vread_pkg::DATA_W-1:0]     rd_data_o
);

   // both banks in one array
   logic [vread_pkg::DATA_W-1:0] mem [2**vread_pkg::BUF_ADDR_W];
   logic [vread_pkg::DATA_W-1:0] rd_data_q;

   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_i.addr] <= wr_i.data;
      end
   end

   // read register holds between enabled steps
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

// ==== write_join.sv ====
`timescale 1ns/1ns

module write_join (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             addr_valid_i,
   input  logic [vread_pkg::BUF_ADDR_W-1:0] addr_i,
   input  logic                             data_valid_i,
   input  logic [vread_pkg::DATA_W-1:0]     data_i,
   output logic                             addr_ready_o,
   output logic                             data_ready_o,
   output vread_pkg::buf_wr_t               wr_o
);

   logic                             take;
   logic                             en_q;
   logic [vread_pkg::BUF_ADDR_W-1:0] addr_q;
   logic [vread_pkg::DATA_W-1:0]     data_q;

   // both sides move together or not at all
   assign take         = addr_valid_i && data_valid_i;
   assign addr_ready_o = take;
   assign data_ready_o = take;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         en_q <= 1'b0;
      end else begin
         en_q <= take;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         addr_q <= addr_i;
         data_q <= data_i;
      end
   end

   always_comb begin
      wr_o.en   = en_q;
      wr_o.addr = addr_q;
      wr_o.data = data_q;
   end

   // an offer that is not taken stays up and unchanged
   a_addr_held: assert property (@(posedge clk) disable iff (rst)
      addr_valid_i && !addr_ready_o |=> addr_valid_i && $stable(addr_i));

   a_data_held: assert property (@(posedge clk) disable iff (rst)
      data_valid_i && !data_ready_o |=> data_valid_i && $stable(data_i));

endmodule

// ==== addr_gen.sv ====
`timescale 1ns/1ns

module addr_gen (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             start_i,
   input  vread_pkg::gen_cfg_t              cfg_i,
   input  logic                             ready_i,
   output logic                             valid_o,
   output logic [vread_pkg::BUF_ADDR_W-1:0] addr_o,
   output logic                             done_o
);

   vread_pkg::gen_state_e            state_q;
   logic [vread_pkg::DELAY_W-1:0]    delay_q;
   logic [vread_pkg::PERIOD_W-1:0]   per_q;
   logic [vread_pkg::COUNT_W-1:0]    iter_q;
   logic [vread_pkg::BUF_ADDR_W-1:0] addr_q;
   logic [vread_pkg::BUF_ADDR_W-1:0] next_addr;
   logic                             enabled;
   logic                             step;
   logic                             per_last;
   logic                             iter_last;
   logic                             done_q;

   assign enabled   = per_q < cfg_i.duty;
   // disabled steps never wait on ready
   assign step      = (state_q == vread_pkg::G_RUN) && (!enabled || ready_i);
   assign per_last  = per_q == cfg_i.period - 1'b1;
   assign iter_last = iter_q == cfg_i.iterations - 1'b1;

   always_comb begin
      next_addr = addr_q;
      if (enabled) begin
         next_addr = next_addr + cfg_i.incr;
      end
      if (per_last) begin
         next_addr = next_addr + cfg_i.shift;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= vread_pkg::G_IDLE;
         delay_q <= '0;
         per_q   <= '0;
         iter_q  <= '0;
         addr_q  <= '0;
         done_q  <= 1'b0;
      end else begin
         done_q <= step && per_last && iter_last;
         case (state_q)
            vread_pkg::G_IDLE: begin
               if (start_i) begin
                  delay_q <= cfg_i.delay;
                  per_q   <= '0;
                  iter_q  <= '0;
                  addr_q  <= cfg_i.start;
                  state_q <= (cfg_i.delay == '0) ? vread_pkg::G_RUN : vread_pkg::G_DELAY;
               end
            end
            vread_pkg::G_DELAY: begin
               delay_q <= delay_q - 1'b1;
               if (delay_q == 1) begin
                  state_q <= vread_pkg::G_RUN;
               end
            end
            vread_pkg::G_RUN: begin
               if (step) begin
                  addr_q <= next_addr;
                  if (per_last) begin
                     per_q  <= '0;
                     iter_q <= iter_q + 1'b1;
                     if (iter_last) begin
                        state_q <= vread_pkg::G_IDLE;
                     end
                  end else begin
                     per_q <= per_q + 1'b1;
                  end
               end
            end
            default: state_q <= vread_pkg::G_IDLE;
         endcase
      end
   end

   assign valid_o = (state_q == vread_pkg::G_RUN) && enabled;
   assign addr_o  = addr_q;
   assign done_o  = done_q;

endmodule

// ==== burst_reader.sv ====
`timescale 1ns/1ns

module burst_reader (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             start_i,
   input  logic [vread_pkg::COUNT_W:0]      count_i,
   input  logic [vread_pkg::BUS_ADDR_W-1:0] start_addr_i,
   input  logic [vread_pkg::BUS_ADDR_W-1:0] addr_shift_i,
   input  logic [vread_pkg::LEN_W-1:0]      burst_len_i,
   input  vread_pkg::bus_rsp_t              bus_rsp_i,
   input  logic                             data_ready_i,
   output vread_pkg::bus_req_t              bus_req_o,
   output logic                             data_valid_o,
   output logic [vread_pkg::DATA_W-1:0]     data_o,
   output logic                             done_o
);

   vread_pkg::reader_state_e         state_q;
   logic [vread_pkg::COUNT_W:0]      remaining_q;
   logic [vread_pkg::COUNT_W:0]      remaining_m1;
   logic [vread_pkg::LEN_W:0]        burst_words;
   logic [vread_pkg::BUS_ADDR_W-1:0] burst_addr_q;
   logic [vread_pkg::LEN_W-1:0]      len_q;
   logic                             hold_valid_q;
   logic [vread_pkg::DATA_W-1:0]     hold_data_q;
   logic                             draining_q;
   logic                             done_q;
   logic                             req_valid;
   logic                             beat;
   logic                             final_beat;
   logic                             handoff;

   assign remaining_m1 = remaining_q - 1'b1;
   assign burst_words  = {1'b0, burst_len_i} + 1'b1;
   // holding register frees in the same cycle it is taken
   assign req_valid    = (state_q == vread_pkg::R_BEAT) && (!hold_valid_q || data_ready_i);
   assign beat         = req_valid && bus_rsp_i.ready;
   assign final_beat   = beat && bus_rsp_i.last && (remaining_m1 == '0);
   assign handoff      = hold_valid_q && data_ready_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q      <= vread_pkg::R_IDLE;
         remaining_q  <= '0;
         burst_addr_q <= '0;
         len_q        <= '0;
      end else begin
         case (state_q)
            vread_pkg::R_IDLE: begin
               if (start_i) begin
                  remaining_q  <= count_i;
                  burst_addr_q <= start_addr_i;
                  state_q      <= vread_pkg::R_REQ;
               end
            end
            vread_pkg::R_REQ: begin
               // short last burst takes the remainder
               if (remaining_q < burst_words) begin
                  len_q <= remaining_m1[vread_pkg::LEN_W-1:0];
               end else begin
                  len_q <= burst_len_i;
               end
               state_q <= vread_pkg::R_BEAT;
            end
            vread_pkg::R_BEAT: begin
               if (beat) begin
                  remaining_q <= remaining_m1;
                  if (bus_rsp_i.last) begin
                     burst_addr_q <= burst_addr_q + addr_shift_i;
                     state_q <= (remaining_m1 == '0) ? vread_pkg::R_IDLE : vread_pkg::R_REQ;
                  end
               end
            end
            default: state_q <= vread_pkg::R_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         hold_valid_q <= 1'b0;
         draining_q   <= 1'b0;
         done_q       <= 1'b0;
      end else begin
         if (beat) begin
            hold_valid_q <= 1'b1;
         end else if (data_ready_i) begin
            hold_valid_q <= 1'b0;
         end
         if (final_beat) begin
            draining_q <= 1'b1;
         end else if (handoff) begin
            draining_q <= 1'b0;
         end
         done_q <= draining_q && handoff;
      end
   end

   always_ff @(posedge clk) begin
      if (beat) begin
         hold_data_q <= bus_rsp_i.rdata;
      end
   end

   always_comb begin
      bus_req_o.valid = req_valid;
      bus_req_o.addr  = burst_addr_q;
      bus_req_o.len   = len_q;
   end

   assign data_valid_o = hold_valid_q;
   assign data_o       = hold_data_q;
   assign done_o       = done_q;

   // valid stays up through a burst unless back-pressured
   a_valid_held: assert property (@(posedge clk) disable iff (rst)
      (bus_req_o.valid && !(beat && bus_rsp_i.last)) ##1 !hold_valid_q |-> bus_req_o.valid);

   a_no_beat_without_valid: assert property (@(posedge clk) disable iff (rst)
      bus_rsp_i.ready |-> bus_req_o.valid);

endmodule

// ==== vread_pkg.sv ====
package vread_pkg;

   localparam int DATA_W     = 32;
   // top bit selects the bank in ping-pong mode
   localparam int BUF_ADDR_W = 7;
   localparam int BUS_ADDR_W = 32;
   localparam int LEN_W      = 8;
   localparam int COUNT_W    = 8;
   localparam int PERIOD_W   = 6;
   localparam int DELAY_W    = 4;

   // request side of the burst bus
   typedef struct packed {
      logic                  valid;
      logic [BUS_ADDR_W-1:0] addr;
      logic [LEN_W-1:0]      len;
   } bus_req_t;

   // ready marks a beat carrying rdata
   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
      logic              last;
   } bus_rsp_t;

   typedef struct packed {
      logic [BUF_ADDR_W-1:0] start;
      logic [BUF_ADDR_W-1:0] incr;
      logic [BUF_ADDR_W-1:0] shift;
      logic [PERIOD_W-1:0]   period;
      logic [PERIOD_W-1:0]   duty;
      logic [COUNT_W-1:0]    iterations;
      logic [DELAY_W-1:0]    delay;
   } gen_cfg_t;

   typedef struct packed {
      logic [BUS_ADDR_W-1:0] ext_addr;
      logic [BUS_ADDR_W-1:0] addr_shift;
      logic [COUNT_W-1:0]    amount_minus_one;
      logic [LEN_W-1:0]      burst_len;
      logic                  enabled;
      logic                  pingpong;
   } read_cfg_t;

   typedef struct packed {
      logic                  en;
      logic [BUF_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } buf_wr_t;

   // states of the burst reader and the address generator
   typedef enum logic [1:0] {R_IDLE, R_REQ, R_BEAT} reader_state_e;
   typedef enum logic [1:0] {G_IDLE, G_DELAY, G_RUN} gen_state_e;

endpackage
